/* logic/bridge_settings_regs.sv */
/*
 * Bridge settings register file
 * holds the core settings written by the host, muxes them back for reads
 * and stretches a reset write into a long core reset pulse
 */

`timescale 1ns/1ps

module bridge_settings_regs import nes_shell_pkg::*; (
  input  logic         clk_74a,
  input  logic         pll_core_locked,

  input  bridge_addr_t bridge_addr,
  input  logic         bridge_wr,
  input  bridge_data_t bridge_wr_data,
  output bridge_data_t bridge_rd_data,

  output logic         hide_overscan,
  output edge_mask_t   mask_vid_edges,
  output logic         allow_extra_sprites,
  output palette_sel_t selected_palette,

  output logic         multitap_enabled,
  output logic         lightgun_enabled,
  output aim_speed_t   lightgun_aim_speed,

  output logic         core_reset
);

  reset_count_t reset_count;

  ////////////////////////////////////////
  // settings writes

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      hide_overscan       <= 1'b0;
      mask_vid_edges      <= '0;
      allow_extra_sprites <= 1'b0;
      selected_palette    <= '0;
      multitap_enabled    <= 1'b0;
      lightgun_enabled    <= 1'b0;
      lightgun_aim_speed  <= '0;
    end else if (bridge_wr) begin
      // full address decode, only the low data bits are kept
      case (bridge_addr)
        addr_hide_overscan: hide_overscan       <= bridge_wr_data[0];
        addr_mask_edges:    mask_vid_edges      <= bridge_wr_data[1:0];
        addr_extra_sprites: allow_extra_sprites <= bridge_wr_data[0];
        addr_palette:       selected_palette    <= bridge_wr_data[2:0];
        addr_multitap:      multitap_enabled    <= bridge_wr_data[0];
        addr_lightgun:      lightgun_enabled    <= bridge_wr_data[0];
        addr_aim_speed:     lightgun_aim_speed  <= bridge_wr_data[7:0];
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////
  // core reset hold counter

  // a new reset write reloads the count even mid-hold
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      reset_count <= '0;
    end else if (bridge_wr && bridge_addr == addr_core_reset) begin
      reset_count <= reset_hold_cycles;
    end else if (reset_count != '0) begin
      reset_count <= reset_count - 1'b1;
    end
  end

  assign core_reset = (reset_count != '0);

  ////////////////////////////////////////
  // readback mux

  // the reset address is write only
  always_comb begin
    bridge_rd_data = '0;
    case (bridge_addr)
      addr_hide_overscan: bridge_rd_data = {31'b0, hide_overscan};
      addr_mask_edges:    bridge_rd_data = {30'b0, mask_vid_edges};
      addr_extra_sprites: bridge_rd_data = {31'b0, allow_extra_sprites};
      addr_palette:       bridge_rd_data = {29'b0, selected_palette};
      addr_multitap:      bridge_rd_data = {31'b0, multitap_enabled};
      addr_lightgun:      bridge_rd_data = {31'b0, lightgun_enabled};
      addr_aim_speed:     bridge_rd_data = {24'b0, lightgun_aim_speed};
      default:            bridge_rd_data = '0;
    endcase
  end

endmodule

/* logic/nes_shell_pkg.sv */
/*
 * NES core shell shared definitions
 * bridge address map, setting widths, key bit positions and video counts
 */

package nes_shell_pkg;

  ////////////////////////////////////////
  // vector types

  typedef logic [31:0] bridge_addr_t;
  typedef logic [31:0] bridge_data_t;
  typedef logic [15:0] cont_key_t;
  // A, B, select, start, up, down, left, right from bit 7 down
  typedef logic [7:0]  nes_pad_t;
  // red in the top byte
  typedef logic [23:0] rgb_t;
  typedef logic [1:0]  edge_mask_t;
  typedef logic [2:0]  palette_sel_t;
  typedef logic [7:0]  aim_speed_t;
  typedef logic [31:0] reset_count_t;

  ////////////////////////////////////////
  // bridge address map

  localparam bridge_addr_t addr_core_reset    = 32'h50;
  localparam bridge_addr_t addr_hide_overscan = 32'h200;
  localparam bridge_addr_t addr_mask_edges    = 32'h204;
  localparam bridge_addr_t addr_extra_sprites = 32'h208;
  localparam bridge_addr_t addr_palette       = 32'h20C;
  localparam bridge_addr_t addr_multitap      = 32'h300;
  localparam bridge_addr_t addr_lightgun      = 32'h304;
  localparam bridge_addr_t addr_aim_speed     = 32'h308;

  ////////////////////////////////////////
  // counts and bit positions

  localparam reset_count_t reset_hold_cycles = 32'h100000;
  localparam logic [2:0]   hs_delay_cycles   = 3'd7;
  localparam int           sync_stages       = 3;

  // controller key bitmap
  localparam int key_up     = 0;
  localparam int key_down   = 1;
  localparam int key_left   = 2;
  localparam int key_right  = 3;
  localparam int key_face_a = 4;
  localparam int key_face_b = 5;
  localparam int key_select = 14;
  localparam int key_start  = 15;

  // end-of-line slot word
  localparam int slot_overscan_bit = 13;

endpackage

/* logic/nes_shell_top.sv */
/*
 * NES core shell top level
 * bridge settings, controller path and video output stage on clk_74a
 */

`timescale 1ns/1ps

module nes_shell_top import nes_shell_pkg::*; (
  input  logic         clk_74a,
  input  logic         pll_core_locked,

  // bridge bus
  input  bridge_addr_t bridge_addr,
  input  logic         bridge_wr,
  input  bridge_data_t bridge_wr_data,
  output bridge_data_t bridge_rd_data,

  // settings towards the core
  output logic         hide_overscan,
  output edge_mask_t   mask_vid_edges,
  output logic         allow_extra_sprites,
  output palette_sel_t selected_palette,
  output logic         multitap_enabled,
  output logic         lightgun_enabled,
  output aim_speed_t   lightgun_aim_speed,
  output logic         core_reset,

  // controllers
  input  cont_key_t    cont1_key,
  input  cont_key_t    cont2_key,
  input  cont_key_t    cont3_key,
  input  cont_key_t    cont4_key,
  output nes_pad_t     pad1,
  output nes_pad_t     pad2,
  output nes_pad_t     pad3,
  output nes_pad_t     pad4,

  // video from the core, out to the scaler
  input  logic         nes_h_blank,
  input  logic         nes_v_blank,
  input  logic         nes_hs,
  input  logic         nes_vs,
  input  rgb_t         nes_rgb,
  output logic         video_de,
  output logic         video_hs,
  output logic         video_vs,
  output rgb_t         video_rgb
);

  bridge_settings_regs bridge_settings_regs_i (
    .clk_74a             (clk_74a),
    .pll_core_locked     (pll_core_locked),
    .bridge_addr         (bridge_addr),
    .bridge_wr           (bridge_wr),
    .bridge_wr_data      (bridge_wr_data),
    .bridge_rd_data      (bridge_rd_data),
    .hide_overscan       (hide_overscan),
    .mask_vid_edges      (mask_vid_edges),
    .allow_extra_sprites (allow_extra_sprites),
    .selected_palette    (selected_palette),
    .multitap_enabled    (multitap_enabled),
    .lightgun_enabled    (lightgun_enabled),
    .lightgun_aim_speed  (lightgun_aim_speed),
    .core_reset          (core_reset)
  );

  pad_input_sync pad_input_sync_i (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .cont1_key       (cont1_key),
    .cont2_key       (cont2_key),
    .cont3_key       (cont3_key),
    .cont4_key       (cont4_key),
    .pad1            (pad1),
    .pad2            (pad2),
    .pad3            (pad3),
    .pad4            (pad4)
  );

  // hide_overscan also feeds the slot word
  video_output_conditioner video_output_conditioner_i (
    .clk_74a         (clk_74a),
    .pll_core_locked (pll_core_locked),
    .hide_overscan   (hide_overscan),
    .nes_h_blank     (nes_h_blank),
    .nes_v_blank     (nes_v_blank),
    .nes_hs          (nes_hs),
    .nes_vs          (nes_vs),
    .nes_rgb         (nes_rgb),
    .video_de        (video_de),
    .video_hs        (video_hs),
    .video_vs        (video_vs),
    .video_rgb       (video_rgb)
  );

endmodule

/* logic/pad_input_sync.sv */
/*
 * Controller input path
 * three register stages per controller, then the NES pad byte mapping
 */

`timescale 1ns/1ps

module pad_input_sync import nes_shell_pkg::*; (
  input  logic      clk_74a,
  input  logic      pll_core_locked,

  input  cont_key_t cont1_key,
  input  cont_key_t cont2_key,
  input  cont_key_t cont3_key,
  input  cont_key_t cont4_key,

  output nes_pad_t  pad1,
  output nes_pad_t  pad2,
  output nes_pad_t  pad3,
  output nes_pad_t  pad4
);

  cont_key_t key_in [4];
  cont_key_t key_pipe [4][sync_stages];

  // pack into A, B, select, start, up, down, left, right
  function automatic nes_pad_t to_pad(input cont_key_t key);
    to_pad = {key[key_face_a], key[key_face_b], key[key_select], key[key_start],
              key[key_up], key[key_down], key[key_left], key[key_right]};
  endfunction

  assign key_in[0] = cont1_key;
  assign key_in[1] = cont2_key;
  assign key_in[2] = cont3_key;
  assign key_in[3] = cont4_key;

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      for (int c = 0; c < 4; c++) begin
        for (int s = 0; s < sync_stages; s++) begin
          key_pipe[c][s] <= '0;
        end
      end
    end else begin
      for (int c = 0; c < 4; c++) begin
        key_pipe[c][0] <= key_in[c];
        for (int s = 1; s < sync_stages; s++) begin
          key_pipe[c][s] <= key_pipe[c][s-1];
        end
      end
    end
  end

  // trigger and face x/y bits are dropped here
  assign pad1 = to_pad(key_pipe[0][sync_stages-1]);
  assign pad2 = to_pad(key_pipe[1][sync_stages-1]);
  assign pad3 = to_pad(key_pipe[2][sync_stages-1]);
  assign pad4 = to_pad(key_pipe[3][sync_stages-1]);

endmodule

/* logic/video_output_conditioner.sv */
/*
 * Video output conditioner
 * registers data enable, pixels and sync for the scaler, with a delayed
 * single-cycle hsync, a single-cycle vsync and the end-of-line slot word
 */

`timescale 1ns/1ps

module video_output_conditioner import nes_shell_pkg::*; (
  input  logic clk_74a,
  input  logic pll_core_locked,

  input  logic hide_overscan,

  input  logic nes_h_blank,
  input  logic nes_v_blank,
  input  logic nes_hs,
  input  logic nes_vs,
  input  rgb_t nes_rgb,

  output logic video_de,
  output logic video_hs,
  output logic video_vs,
  output rgb_t video_rgb
);

  logic       de;
  logic       de_prev;
  logic       hs_prev;
  logic       vs_prev;
  logic [2:0] hs_count;
  rgb_t       slot_word;

  assign de = ~(nes_h_blank | nes_v_blank);

  // slot word only carries the overscan flag for now
  always_comb begin
    slot_word = '0;
    slot_word[slot_overscan_bit] = hide_overscan;
  end

  ////////////////////////////////////////
  // edge history

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      de_prev <= 1'b0;
      hs_prev <= 1'b0;
      vs_prev <= 1'b0;
    end else begin
      de_prev <= de;
      hs_prev <= nes_hs;
      vs_prev <= nes_vs;
    end
  end

  ////////////////////////////////////////
  // registered outputs

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      hs_count  <= '0;
      video_de  <= 1'b0;
      video_hs  <= 1'b0;
      video_vs  <= 1'b0;
      video_rgb <= '0;
    end else begin
      // hsync is pushed back so it never lands on the vsync pulse
      if (nes_hs && !hs_prev) begin
        hs_count <= hs_delay_cycles;
      end else if (hs_count != '0) begin
        hs_count <= hs_count - 1'b1;
      end
      video_hs <= (hs_count == 3'd1);

      video_vs <= nes_vs && !vs_prev;
      video_de <= de;

      if (de) begin
        video_rgb <= nes_rgb;
      end else if (de_prev) begin
        // first blank cycle after the active line
        video_rgb <= slot_word;
      end else begin
        video_rgb <= '0;
      end
    end
  end

endmodule

/* nes_core_shell.f */
logic/nes_shell_pkg.sv
logic/bridge_settings_regs.sv
logic/pad_input_sync.sv
logic/video_output_conditioner.sv
logic/nes_shell_top.sv
sim/nes_shell_properties.sv
sim/nes_shell_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the NES shell testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module nes_shell_tb -f nes_core_shell.f -Mdir obj_dir; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vnes_shell_tb)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qxF "TEST OK" <<< "$sim_out"; then
  echo "PASS"
  exit 0
fi

echo "FAIL"
exit 1

/* sim/nes_shell_properties.sv */
/*
 * NES shell output properties
 * single-cycle sync pulses and quiet outputs while in reset
 */

`timescale 1ns/1ps

module nes_shell_properties import nes_shell_pkg::*; (
  input logic         clk_74a,
  input logic         pll_core_locked,
  input bridge_data_t bridge_rd_data,
  input logic         hide_overscan, allow_extra_sprites, multitap_enabled, lightgun_enabled,
  input edge_mask_t   mask_vid_edges,
  input palette_sel_t selected_palette,
  input aim_speed_t   lightgun_aim_speed,
  input logic         core_reset,
  input nes_pad_t     pad1, pad2, pad3, pad4,
  input logic         video_de, video_hs, video_vs,
  input rgb_t         video_rgb
);

  // failures seen so far, read by the testbench summary
  int assert_fails = 0;

  vs_single: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    video_vs |=> !video_vs)
    else begin
      $error("video_vs stayed high for two cycles");
      assert_fails++;
    end

  hs_single: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    video_hs |=> !video_hs)
    else begin
      $error("video_hs stayed high for two cycles");
      assert_fails++;
    end

  reset_quiet: assert property (@(posedge clk_74a) !pll_core_locked |->
    ({bridge_rd_data, hide_overscan, allow_extra_sprites, multitap_enabled,
      lightgun_enabled, mask_vid_edges, selected_palette, lightgun_aim_speed,
      core_reset, pad1, pad2, pad3, pad4, video_de, video_hs, video_vs,
      video_rgb} == '0))
    else begin
      $error("shell output not low during reset");
      assert_fails++;
    end

endmodule

bind nes_shell_top nes_shell_properties nes_shell_properties_i (.*);

/* sim/nes_shell_tb.sv */
/*
 * NES shell testbench
 * bridge, controller and video stimulus with a reference model that
 * checks every shell output on each clock
 */

`timescale 1ns/1ps

module nes_shell_tb import nes_shell_pkg::*; ();

  logic         clk_74a;
  logic         pll_core_locked;
  bridge_addr_t bridge_addr;
  logic         bridge_wr;
  bridge_data_t bridge_wr_data;
  bridge_data_t bridge_rd_data;
  logic         hide_overscan, allow_extra_sprites, multitap_enabled, lightgun_enabled;
  edge_mask_t   mask_vid_edges;
  palette_sel_t selected_palette;
  aim_speed_t   lightgun_aim_speed;
  logic         core_reset;
  cont_key_t    cont1_key, cont2_key, cont3_key, cont4_key;
  nes_pad_t     pad1, pad2, pad3, pad4;
  logic         nes_h_blank, nes_v_blank, nes_hs, nes_vs;
  rgb_t         nes_rgb;
  logic         video_de, video_hs, video_vs;
  rgb_t         video_rgb;

  int unsigned  errors = 0;
  int unsigned  checks = 0;
  logic [31:0]  cycle_count = '0;
  logic [31:0]  rnd;
  int unsigned  hold;

  // reference model state advanced once per edge
  logic         sh_hide, sh_extra, sh_multi, sh_gun;
  edge_mask_t   sh_mask;
  palette_sel_t sh_pal;
  aim_speed_t   sh_aim;
  reset_count_t reset_left;
  cont_key_t    key_hist [4][sync_stages];
  cont_key_t    key_now [4];
  logic         exp_de, exp_hs, exp_vs, hs_last, vs_last, de_now;
  rgb_t         exp_rgb;
  logic [7:0]   rise_hist;

  bridge_addr_t settings_addrs [7] = '{addr_hide_overscan, addr_mask_edges,
    addr_extra_sprites, addr_palette, addr_multitap, addr_lightgun, addr_aim_speed};
  bridge_addr_t unmapped_addrs [5] = '{addr_core_reset, 32'h0, 32'h54, 32'h210,
    32'hFFFF_0200};

  nes_shell_top nes_shell_top_i (.*);

  initial begin
    clk_74a = 1'b0;
    forever #5 clk_74a = ~clk_74a;
  end

  ////////////////////////////////////////
  // reference functions and helpers

  // NES order A, B, select, start, up, down, left, right
  function automatic nes_pad_t ref_pad(input cont_key_t key);
    return {key[key_face_a], key[key_face_b], key[key_select], key[key_start],
            key[key_up], key[key_down], key[key_left], key[key_right]};
  endfunction

  function automatic bridge_data_t ref_readback(input bridge_addr_t addr);
    case (addr)
      addr_hide_overscan: return {31'b0, sh_hide};
      addr_mask_edges:    return {30'b0, sh_mask};
      addr_extra_sprites: return {31'b0, sh_extra};
      addr_palette:       return {29'b0, sh_pal};
      addr_multitap:      return {31'b0, sh_multi};
      addr_lightgun:      return {31'b0, sh_gun};
      addr_aim_speed:     return {24'b0, sh_aim};
      default:            return '0;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("CHECK FAILED %s: got %h expected %h at %0t", name, got, expected, $time);
    end
  endtask

  // one-cycle write strobe that leaves the address on the bus
  task automatic bridge_write(input bridge_addr_t addr, input bridge_data_t data);
    bridge_addr = addr;
    bridge_wr_data = data;
    bridge_wr = 1'b1;
    @(negedge clk_74a);
    bridge_wr = 1'b0;
  endtask

  // random blanking and pixels with hsync lines of 10 to 25 cycles
  task automatic run_video(input int cycles);
    int          hs_phase;
    int          hs_len;
    logic [31:0] r;
    logic [31:0] pix;
    hs_phase = 0;
    hs_len = 0;
    repeat (cycles) begin
      r = $urandom;
      pix = $urandom;
      if (hs_phase == 0) begin
        hs_phase = 10 + int'(r[3:0]);
        hs_len = 1 + int'(r[5:4]);
      end
      nes_hs = (hs_phase <= hs_len);
      hs_phase--;
      nes_vs = (r[9:6] == 4'd0);
      nes_h_blank = (r[11:10] == 2'd0);
      nes_v_blank = (r[14:12] == 3'd0);
      nes_rgb = pix[23:0];
      @(negedge clk_74a);
    end
    // quiet gap so the next hsync edge stays clear of the delay window
    nes_hs = 1'b0;
    repeat (8) @(negedge clk_74a);
  endtask

  ////////////////////////////////////////
  // compare process

  // outputs seen here are the result of the previous edge
  always @(posedge clk_74a) begin
    if (!pll_core_locked) begin
      {sh_hide, sh_mask, sh_extra, sh_pal, sh_multi, sh_gun, sh_aim} = '0;
      {exp_de, exp_hs, exp_vs, hs_last, vs_last} = '0;
      reset_left = '0;
      exp_rgb = '0;
      rise_hist = '0;
      foreach (key_hist[c, s]) key_hist[c][s] = '0;
    end else begin
      check_value("bridge_rd_data", bridge_rd_data, ref_readback(bridge_addr));
      check_value("hide_overscan", hide_overscan, sh_hide);
      check_value("mask_vid_edges", mask_vid_edges, sh_mask);
      check_value("allow_extra_sprites", allow_extra_sprites, sh_extra);
      check_value("selected_palette", selected_palette, sh_pal);
      check_value("multitap_enabled", multitap_enabled, sh_multi);
      check_value("lightgun_enabled", lightgun_enabled, sh_gun);
      check_value("lightgun_aim_speed", lightgun_aim_speed, sh_aim);
      check_value("core_reset", core_reset, reset_left != '0);
      check_value("pad1", pad1, ref_pad(key_hist[0][sync_stages-1]));
      check_value("pad2", pad2, ref_pad(key_hist[1][sync_stages-1]));
      check_value("pad3", pad3, ref_pad(key_hist[2][sync_stages-1]));
      check_value("pad4", pad4, ref_pad(key_hist[3][sync_stages-1]));
      check_value("video_de", video_de, exp_de);
      check_value("video_hs", video_hs, exp_hs);
      check_value("video_vs", video_vs, exp_vs);
      check_value("video_rgb", video_rgb, exp_rgb);

      // video uses the overscan setting held before this edge
      de_now = !(nes_h_blank || nes_v_blank);
      exp_rgb = '0;
      if (de_now) begin
        exp_rgb = nes_rgb;
      end else if (exp_de) begin
        exp_rgb[slot_overscan_bit] = sh_hide;
      end
      exp_de = de_now;
      exp_vs = nes_vs && !vs_last;
      rise_hist = {rise_hist[6:0], nes_hs && !hs_last};
      exp_hs = rise_hist[hs_delay_cycles];
      hs_last = nes_hs;
      vs_last = nes_vs;

      key_now = '{cont1_key, cont2_key, cont3_key, cont4_key};
      for (int c = 0; c < 4; c++) begin
        for (int s = sync_stages - 1; s > 0; s--) key_hist[c][s] = key_hist[c][s-1];
        key_hist[c][0] = key_now[c];
      end

      if (bridge_wr && bridge_addr == addr_core_reset) begin
        reset_left = reset_hold_cycles;
      end else if (reset_left != '0) begin
        reset_left = reset_left - 1;
      end
      if (bridge_wr) begin
        case (bridge_addr)
          addr_hide_overscan: sh_hide = bridge_wr_data[0];
          addr_mask_edges:    sh_mask = bridge_wr_data[1:0];
          addr_extra_sprites: sh_extra = bridge_wr_data[0];
          addr_palette:       sh_pal = bridge_wr_data[2:0];
          addr_multitap:      sh_multi = bridge_wr_data[0];
          addr_lightgun:      sh_gun = bridge_wr_data[0];
          addr_aim_speed:     sh_aim = bridge_wr_data[7:0];
          default: ;
        endcase
      end
    end
  end

  // run limit covers the long reset hold twice over
  always @(posedge clk_74a) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > 2 * reset_hold_cycles + 4000) begin
      $display("timeout: run did not finish after %0d cycles, %0d errors", cycle_count, errors);
      $display("TEST FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////
  // stimulus

  initial begin
    void'($urandom(32'h4a61d24c));
    pll_core_locked = 1'b1;
    bridge_addr = '0;
    bridge_wr = 1'b0;
    bridge_wr_data = '0;
    {cont1_key, cont2_key, cont3_key, cont4_key} = '0;
    {nes_h_blank, nes_v_blank, nes_hs, nes_vs} = '0;
    nes_rgb = '0;
    // falling edge starts the async reset
    #1 pll_core_locked = 1'b0;
    repeat (4) @(negedge clk_74a);
    pll_core_locked = 1'b1;

    // reset state of every readback address
    foreach (settings_addrs[i]) begin
      bridge_addr = settings_addrs[i];
      @(negedge clk_74a);
    end

    // random settings writes
    repeat (80) begin
      rnd = $urandom;
      bridge_write(settings_addrs[rnd % 7], $urandom);
    end
    bridge_write(32'h210, 32'hFFFF_FFFF);

    // readback of the last value written to each address
    foreach (settings_addrs[i]) begin
      bridge_addr = settings_addrs[i];
      @(negedge clk_74a);
    end

    // unmapped and write-only addresses read as zero
    foreach (unmapped_addrs[i]) begin
      bridge_addr = unmapped_addrs[i];
      @(negedge clk_74a);
    end

    // controllers change every cycle
    repeat (200) begin
      rnd = $urandom;
      cont1_key = rnd[15:0];
      cont2_key = rnd[31:16];
      rnd = $urandom;
      cont3_key = rnd[15:0];
      cont4_key = rnd[31:16];
      @(negedge clk_74a);
    end

    // video with the slot word carrying both overscan values
    bridge_write(addr_hide_overscan, 32'h0);
    run_video(400);
    bridge_write(addr_hide_overscan, 32'h1);
    run_video(400);

    // core reset hold restarted partway through
    bridge_write(addr_core_reset, 32'h1);
    repeat (100) @(negedge clk_74a);
    bridge_write(addr_core_reset, 32'h1);
    hold = 0;
    while (core_reset) begin
      hold++;
      @(negedge clk_74a);
    end
    check_value("core_reset hold cycles", hold, reset_hold_cycles);

    repeat (4) @(negedge clk_74a);
    errors = errors + nes_shell_top_i.nes_shell_properties_i.assert_fails;
    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
